/* project.f */
+incdir+verilog
verilog/pci_bridge_pkg.sv
verilog/target_if.sv
verilog/axi_window_master.sv
verilog/local_reg_file.sv
verilog/target_response_mux.sv
verilog/pci_target_bridge.sv
verification/tb_pci_target_bridge.sv

/* Bender.yml */
package:
  name: pci_target_bridge

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pci_bridge_pkg.sv
      - verilog/target_if.sv
      - verilog/axi_window_master.sv
      - verilog/local_reg_file.sv
      - verilog/target_response_mux.sv
      - verilog/pci_target_bridge.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_pci_target_bridge.sv

/* verification/tb_pci_target_bridge.sv */
`default_nettype none
`timescale 1ns/1ns

`include "pci_bridge_macros.svh"

module tb_pci_target_bridge;
	import pci_bridge_pkg::*;

	logic       clk;
	logic       rst_n;
	addr_t      addr;
	data_t      adio_out;
	logic       addr_vld;
	logic [7:0] base_hit;
	logic       s_wrdn;
	logic       s_data_vld;
	logic [3:0] s_cbe;
	data_t      adio_in;
	logic       s_ready;
	logic       s_term;
	logic       s_abort;
	addr_t      m_awaddr;
	logic       m_awvalid;
	logic       m_awready;
	data_t      m_wdata;
	be_t        m_wstrb;
	logic       m_wvalid;
	logic       m_wready;
	axi_resp_t  m_bresp;
	logic       m_bvalid;
	logic       m_bready;
	addr_t      m_araddr;
	logic       m_arvalid;
	logic       m_arready;
	data_t      m_rdata;
	axi_resp_t  m_rresp;
	logic       m_rvalid;
	logic       m_rready;

	// AXI slave model state
	data_t      mem [addr_t];
	logic       aw_got;
	logic       w_got;
	logic       ar_got;
	addr_t      aw_addr;
	addr_t      ar_addr;
	data_t      w_data;
	be_t        w_strb;
	int         b_wait;
	int         r_wait;
	logic       b_fire;
	logic       r_fire;
	addr_t      last_axi_addr;

	// Shadow state for the reference
	data_t      shadow_win [logic [21:0]];
	data_t      shadow_reg [1:3];
	int         accesses;
	int         term_count;

	pci_target_bridge dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string what);
		$display("%s at %0t", what, $time);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
			fail_run("Data mismatch");
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
			fail_run("Address mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s expected %b, got %b", $time, name, exp, got);
			fail_run("Flag mismatch");
		end
	endtask

	function automatic data_t merge_bytes(input data_t old, input data_t wd, input be_t be);
		data_t res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (be[b])
				res[8*b +: 8] = wd[8*b +: 8];
		return res;
	endfunction

	// Predicts read data and abort, and updates the shadow copies on writes
	function automatic data_t ref_access(input addr_t a, input logic [7:0] hit, input logic wr,
			input data_t wd, input be_t be, output logic abort);
		data_t old;
		if (hit[0]) begin
			abort = a[23:20] == 4'hf;
			old = shadow_win.exists(a[23:2]) ? shadow_win[a[23:2]] : '0;
			if (wr && !abort)
				shadow_win[a[23:2]] = merge_bytes(old, wd, be);
			return abort ? '0 : old;
		end
		abort = (|a[31:4]) || (wr && a[3:2] == 2'd0);
		if (|a[31:4])
			return '0;
		if (a[3:2] == 2'd0)
			return `PCI_REG_ID;
		old = shadow_reg[a[3:2]];
		if (wr)
			shadow_reg[a[3:2]] = merge_bytes(old, wd, be);
		return old;
	endfunction

	// One single-phase access as the PCI core issues it
	task automatic run_access(input addr_t a, input logic [7:0] hit, input logic wr,
			input data_t wd, input be_t be);
		data_t exp_data;
		logic  exp_abort;
		int    cycles;
		exp_data = ref_access(a, hit, wr, wd, be, exp_abort);
		@(negedge clk);
		addr     = a;
		base_hit = hit;
		s_wrdn   = wr;
		addr_vld = 1'b1;
		@(negedge clk);
		addr_vld = 1'b0;
		base_hit = '0;
		if (wr) begin
			cycles = 0;
			while (!s_ready) begin
				if (cycles >= 50)
					fail_run("Timeout waiting for s_ready in the data phase");
				@(negedge clk);
				cycles++;
			end
			adio_out   = wd;
			s_cbe      = ~be;
			s_data_vld = 1'b1;
			@(negedge clk);
			s_data_vld = 1'b0;
		end
		cycles = 0;
		while (!s_term) begin
			if (cycles >= 200)
				fail_run("Timeout waiting for s_term");
			@(negedge clk);
			cycles++;
		end
		check_flag("s_abort", s_abort, exp_abort);
		check_flag("s_ready", s_ready, !exp_abort);
		if (!wr)
			check_data("adio_in", adio_in, exp_data);
		if (hit[0])
			check_addr("axi addr", last_axi_addr,
				`PCI_WIN_BASE + {8'h00, a[23:0]});
		accesses++;
		@(negedge clk);
		check_flag("s_term", s_term, 1'b0);
	endtask

	task automatic unclaimed_phase(input logic [7:0] hit);
		@(negedge clk);
		addr     = $urandom;
		base_hit = hit;
		s_wrdn   = $urandom_range(0, 1);
		addr_vld = 1'b1;
		@(negedge clk);
		addr_vld = 1'b0;
		base_hit = '0;
		repeat (10) begin
			check_flag("s_ready", s_ready, 1'b0);
			check_flag("s_term", s_term, 1'b0);
			check_flag("s_abort", s_abort, 1'b0);
			check_flag("m_awvalid", m_awvalid, 1'b0);
			check_flag("m_wvalid", m_wvalid, 1'b0);
			check_flag("m_arvalid", m_arvalid, 1'b0);
			@(negedge clk);
		end
	endtask

	always @(negedge clk)
		if (rst_n && s_term)
			term_count++;

	// AXI-lite slave with random ready and response delays
	always @(negedge clk) begin
		if (!rst_n) begin
			{aw_got, w_got, ar_got, b_fire, r_fire} = '0;
			{m_awready, m_wready, m_arready, m_bvalid, m_rvalid} = '0;
		end else begin
			if (b_fire)
				m_bvalid = 1'b0;
			if (r_fire)
				m_rvalid = 1'b0;
			{b_fire, r_fire, m_awready, m_wready, m_arready} = '0;
			if (aw_got && w_got) begin
				if (b_wait > 0) begin
					b_wait--;
				end else begin
					m_bresp = aw_addr[23:20] == 4'hf ? 2'b10 : 2'b00;
					if (m_bresp == 2'b00)
						mem[{aw_addr[31:2], 2'b00}] = merge_bytes(
							mem.exists({aw_addr[31:2], 2'b00}) ? mem[{aw_addr[31:2], 2'b00}] : '0,
							w_data, w_strb);
					m_bvalid = 1'b1;
					aw_got   = 1'b0;
					w_got    = 1'b0;
				end
			end
			if (ar_got) begin
				if (r_wait > 0) begin
					r_wait--;
				end else begin
					m_rresp  = ar_addr[23:20] == 4'hf ? 2'b10 : 2'b00;
					m_rdata  = (m_rresp == 2'b00 && mem.exists({ar_addr[31:2], 2'b00})) ?
						mem[{ar_addr[31:2], 2'b00}] : '0;
					m_rvalid = 1'b1;
					ar_got   = 1'b0;
				end
			end
			if (m_awvalid && !aw_got && $urandom_range(0, 2) == 0) begin
				m_awready     = 1'b1;
				aw_got        = 1'b1;
				aw_addr       = m_awaddr;
				last_axi_addr = m_awaddr;
				b_wait        = $urandom_range(0, 3);
			end
			if (m_wvalid && !w_got && $urandom_range(0, 2) == 0) begin
				m_wready = 1'b1;
				w_got    = 1'b1;
				w_data   = m_wdata;
				w_strb   = m_wstrb;
				b_wait   = $urandom_range(0, 3);
			end
			if (m_arvalid && !ar_got && $urandom_range(0, 2) == 0) begin
				m_arready     = 1'b1;
				ar_got        = 1'b1;
				ar_addr       = m_araddr;
				last_axi_addr = m_araddr;
				r_wait        = $urandom_range(0, 3);
			end
			// Response transfers on the next rising edge
			b_fire = m_bvalid && m_bready;
			r_fire = m_rvalid && m_rready;
		end
	end

	initial begin
		addr_t a;
		data_t d;
		void'($urandom(18));
		{rst_n, addr, adio_out, addr_vld, base_hit, s_wrdn, s_data_vld} = '0;
		s_cbe = 4'hf;
		{m_awready, m_wready, m_bvalid, m_arready, m_rvalid} = '0;
		{m_bresp, m_rresp, m_rdata} = '0;
		{accesses, term_count, b_wait, r_wait} = '0;
		for (int i = 1; i < 4; i++)
			shadow_reg[i] = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// Register bank
		run_access(32'h0, 8'h02, 1'b0, '0, '0);
		repeat (16) begin
			a = {28'h0, 2'($urandom_range(1, 3)), 2'b00};
			run_access(a, 8'h02, 1'b1, $urandom, 4'($urandom));
			run_access(a, 8'h02, 1'b0, '0, '0);
		end
		run_access(32'h0, 8'h02, 1'b1, $urandom, 4'hf);
		run_access(32'h10, 8'h02, 1'b0, '0, '0);
		run_access(32'h124, 8'h02, 1'b0, '0, '0);
		run_access(32'h0, 8'h02, 1'b0, '0, '0);

		// Window with back-pressure
		repeat (24) begin
			a = {$urandom} & 32'hffff_fffc;
			if (a[23:20] == 4'hf)
				a[23] = 1'b0;
			d = $urandom;
			run_access(a, 8'h01, 1'b1, d, 4'($urandom));
			run_access(a, 8'h01, 1'b0, '0, '0);
			run_access(a, 8'h01, 1'b1, ~d, 4'hf);
			run_access(a, 8'h01, 1'b0, '0, '0);
		end

		// SLVERR region
		run_access(32'h00f0_0040, 8'h01, 1'b1, $urandom, 4'hf);
		run_access(32'h12fa_bcd8, 8'h01, 1'b0, '0, '0);

		unclaimed_phase(8'h00);
		unclaimed_phase(8'h04);

		if (term_count != accesses)
			fail_run("Number of s_term pulses differs from the number of accesses");
		else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog/pci_target_bridge.sv */
`default_nettype none
`timescale 1ns/1ns

module pci_target_bridge (
	input  wire                       clk,
	input  wire                       rst_n,

	// PCI core target side
	input  pci_bridge_pkg::addr_t     addr,
	input  pci_bridge_pkg::data_t     adio_out,
	input  wire                       addr_vld,
	input  wire [7:0]                 base_hit,
	input  wire                       s_wrdn,
	input  wire                       s_data_vld,
	input  wire [3:0]                 s_cbe,
	output pci_bridge_pkg::data_t     adio_in,
	output logic                      s_ready,
	output logic                      s_term,
	output logic                      s_abort,

	// AXI-lite master for the BAR0 window
	output pci_bridge_pkg::addr_t     m_awaddr,
	output logic                      m_awvalid,
	input  wire                       m_awready,
	output pci_bridge_pkg::data_t     m_wdata,
	output pci_bridge_pkg::be_t       m_wstrb,
	output logic                      m_wvalid,
	input  wire                       m_wready,
	input  pci_bridge_pkg::axi_resp_t m_bresp,
	input  wire                       m_bvalid,
	output logic                      m_bready,
	output pci_bridge_pkg::addr_t     m_araddr,
	output logic                      m_arvalid,
	input  wire                       m_arready,
	input  pci_bridge_pkg::data_t     m_rdata,
	input  pci_bridge_pkg::axi_resp_t m_rresp,
	input  wire                       m_rvalid,
	output logic                      m_rready
);

	target_req_if win_req ();
	target_rsp_if win_rsp ();
	target_req_if loc_req ();
	target_rsp_if loc_rsp ();

	target_response_mux target_response_mux_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (addr),
		.adio_out   (adio_out),
		.addr_vld   (addr_vld),
		.base_hit   (base_hit),
		.s_wrdn     (s_wrdn),
		.s_data_vld (s_data_vld),
		.s_cbe      (s_cbe),
		.adio_in    (adio_in),
		.s_ready    (s_ready),
		.s_term     (s_term),
		.s_abort    (s_abort),
		.win_req    (win_req.master),
		.win_rsp    (win_rsp.master),
		.loc_req    (loc_req.master),
		.loc_rsp    (loc_rsp.master)
	);

	axi_window_master axi_window_master_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (win_req.slave),
		.rsp       (win_rsp.slave),
		.m_awaddr  (m_awaddr),
		.m_awvalid (m_awvalid),
		.m_awready (m_awready),
		.m_wdata   (m_wdata),
		.m_wstrb   (m_wstrb),
		.m_wvalid  (m_wvalid),
		.m_wready  (m_wready),
		.m_bresp   (m_bresp),
		.m_bvalid  (m_bvalid),
		.m_bready  (m_bready),
		.m_araddr  (m_araddr),
		.m_arvalid (m_arvalid),
		.m_arready (m_arready),
		.m_rdata   (m_rdata),
		.m_rresp   (m_rresp),
		.m_rvalid  (m_rvalid),
		.m_rready  (m_rready)
	);

	local_reg_file local_reg_file_i (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (loc_req.slave),
		.rsp   (loc_rsp.slave)
	);

endmodule

`default_nettype wire

/* verilog/target_response_mux.sv */
`default_nettype none
`timescale 1ns/1ns

module target_response_mux (
	input  wire                   clk,
	input  wire                   rst_n,

	input  pci_bridge_pkg::addr_t addr,
	input  pci_bridge_pkg::data_t adio_out,
	input  wire                   addr_vld,
	input  wire [7:0]             base_hit,
	input  wire                   s_wrdn,
	input  wire                   s_data_vld,
	input  wire [3:0]             s_cbe,
	output pci_bridge_pkg::data_t adio_in,
	output logic                  s_ready,
	output logic                  s_term,
	output logic                  s_abort,

	target_req_if.master          win_req,
	target_rsp_if.master          win_rsp,
	target_req_if.master          loc_req,
	target_rsp_if.master          loc_rsp
);
	import pci_bridge_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_wait_data,
		st_busy,
		st_finish
	} state_t;

	state_t   state_q;
	tgt_sel_t sel_q;
	logic     req_q;
	logic     claim;
	addr_t    addr_q;
	data_t    wdata_q;
	be_t      be_q;
	logic     write_q;
	data_t    rdata_q;
	logic     err_q;
	logic     sel_done;
	data_t    sel_rdata;
	logic     sel_err;

	// Only BAR0 and BAR1 belong to this bridge
	assign claim = addr_vld && (base_hit[0] || base_hit[1]);

	assign win_req.addr  = addr_q;
	assign win_req.wdata = wdata_q;
	assign win_req.be    = be_q;
	assign win_req.write = write_q;
	assign win_req.req   = req_q && sel_q == sel_window;

	assign loc_req.addr  = addr_q;
	assign loc_req.wdata = wdata_q;
	assign loc_req.be    = be_q;
	assign loc_req.write = write_q;
	assign loc_req.req   = req_q && sel_q == sel_local;

	always_comb begin
		sel_done  = 1'b0;
		sel_rdata = '0;
		sel_err   = 1'b0;
		case (sel_q)
			sel_window: begin
				sel_done  = win_rsp.done;
				sel_rdata = win_rsp.rdata;
				sel_err   = win_rsp.err;
			end
			sel_local: begin
				sel_done  = loc_rsp.done;
				sel_rdata = loc_rsp.rdata;
				sel_err   = loc_rsp.err;
			end
			default: ;
		endcase
	end

	// Ready doubles as the write data handshake
	assign s_ready = (state_q == st_wait_data) || (state_q == st_finish && !err_q);
	assign s_term  = state_q == st_finish;
	assign s_abort = state_q == st_finish && err_q;
	assign adio_in = rdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= st_idle;
			sel_q   <= sel_none;
			req_q   <= 1'b0;
		end else begin
			req_q <= 1'b0;
			case (state_q)
				st_idle: begin
					if (claim) begin
						sel_q <= base_hit[0] ? sel_window : sel_local;
						if (s_wrdn) begin
							state_q <= st_wait_data;
						end else begin
							state_q <= st_busy;
							req_q   <= 1'b1;
						end
					end
				end
				st_wait_data: begin
					if (s_data_vld) begin
						state_q <= st_busy;
						req_q   <= 1'b1;
					end
				end
				st_busy: begin
					if (sel_done)
						state_q <= st_finish;
				end
				st_finish: begin
					state_q <= st_idle;
					sel_q   <= sel_none;
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == st_idle && claim) begin
			addr_q  <= addr;
			write_q <= s_wrdn;
			be_q    <= '1;
		end
		// Core byte enables are active low
		if (state_q == st_wait_data && s_data_vld) begin
			wdata_q <= adio_out;
			be_q    <= ~s_cbe;
		end
		if (state_q == st_busy && sel_done) begin
			rdata_q <= sel_rdata;
			err_q   <= sel_err;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		win_rsp.done |-> sel_q == sel_window && state_q == st_busy);
	assert property (@(posedge clk) disable iff (!rst_n)
		loc_rsp.done |-> sel_q == sel_local && state_q == st_busy);

endmodule

`default_nettype wire

/* verilog/local_reg_file.sv */
`default_nettype none
`timescale 1ns/1ns

`include "pci_bridge_macros.svh"

module local_reg_file (
	input  wire         clk,
	input  wire         rst_n,

	target_req_if.slave req,
	target_rsp_if.slave rsp
);
	import pci_bridge_pkg::*;

	localparam int IDX_BITS = $clog2(`PCI_REG_WORDS);

	data_t               regs_q [1:`PCI_REG_WORDS-1];
	logic [IDX_BITS-1:0] word_idx;
	logic                out_of_bank;
	data_t               read_word;
	logic                done_q;
	data_t               rdata_q;
	logic                err_q;

	assign word_idx    = req.addr[IDX_BITS+1:2];
	assign out_of_bank = |(req.addr >> (IDX_BITS + 2));

	// Word 0 is the fixed identity
	assign read_word = out_of_bank ? '0 :
		(word_idx == '0) ? `PCI_REG_ID : regs_q[word_idx];

	assign rsp.done  = done_q;
	assign rsp.rdata = rdata_q;
	assign rsp.err   = err_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done_q <= 1'b0;
			for (int i = 1; i < `PCI_REG_WORDS; i++)
				regs_q[i] <= '0;
		end else begin
			done_q <= req.req;
			if (req.req && req.write && !out_of_bank && word_idx != '0) begin
				for (int b = 0; b < 4; b++)
					if (req.be[b])
						regs_q[word_idx][8*b +: 8] <= req.wdata[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req.req) begin
			rdata_q <= read_word;
			err_q   <= out_of_bank || (req.write && word_idx == '0);
		end
	end

	// Combiner never issues back to back requests here
	assert property (@(posedge clk) disable iff (!rst_n)
		req.req |=> !req.req);

endmodule

`default_nettype wire

/* verilog/axi_window_master.sv */
`default_nettype none
`timescale 1ns/1ns

`include "pci_bridge_macros.svh"

module axi_window_master (
	input  wire                       clk,
	input  wire                       rst_n,

	target_req_if.slave               req,
	target_rsp_if.slave               rsp,

	output pci_bridge_pkg::addr_t     m_awaddr,
	output logic                      m_awvalid,
	input  wire                       m_awready,

	output pci_bridge_pkg::data_t     m_wdata,
	output pci_bridge_pkg::be_t       m_wstrb,
	output logic                      m_wvalid,
	input  wire                       m_wready,

	input  pci_bridge_pkg::axi_resp_t m_bresp,
	input  wire                       m_bvalid,
	output logic                      m_bready,

	output pci_bridge_pkg::addr_t     m_araddr,
	output logic                      m_arvalid,
	input  wire                       m_arready,

	input  pci_bridge_pkg::data_t     m_rdata,
	input  pci_bridge_pkg::axi_resp_t m_rresp,
	input  wire                       m_rvalid,
	output logic                      m_rready
);
	import pci_bridge_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_write,
		st_bresp,
		st_raddr,
		st_rdata
	} state_t;

	state_t state_q;
	logic   awvalid_q;
	logic   wvalid_q;
	logic   arvalid_q;
	addr_t  win_addr;

	// Window offset rebased into AXI space
	assign win_addr = `PCI_WIN_BASE + addr_t'(req.addr[`PCI_WIN_ADDR_BITS-1:0]);

	// Payload comes straight from the held request
	assign m_awaddr = win_addr;
	assign m_araddr = win_addr;
	assign m_wdata  = req.wdata;
	assign m_wstrb  = req.be;

	assign m_awvalid = awvalid_q;
	assign m_wvalid  = wvalid_q;
	assign m_arvalid = arvalid_q;
	assign m_bready  = state_q == st_bresp;
	assign m_rready  = state_q == st_rdata;

	// Completion in the cycle the response transfers
	assign rsp.done  = (m_bready && m_bvalid) || (m_rready && m_rvalid);
	assign rsp.rdata = m_rdata;
	assign rsp.err   = m_bready ? (m_bresp != AXI_OKAY) : (m_rresp != AXI_OKAY);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= st_idle;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			arvalid_q <= 1'b0;
		end else begin
			case (state_q)
				st_idle: begin
					if (req.req && req.write) begin
						awvalid_q <= 1'b1;
						wvalid_q  <= 1'b1;
						state_q   <= st_write;
					end else if (req.req) begin
						arvalid_q <= 1'b1;
						state_q   <= st_raddr;
					end
				end
				st_write: begin
					// Address and data may be taken in either order
					if (m_awready)
						awvalid_q <= 1'b0;
					if (m_wready)
						wvalid_q <= 1'b0;
					if ((m_awready || !awvalid_q) && (m_wready || !wvalid_q))
						state_q <= st_bresp;
				end
				st_bresp: begin
					if (m_bvalid)
						state_q <= st_idle;
				end
				st_raddr: begin
					if (m_arready) begin
						arvalid_q <= 1'b0;
						state_q   <= st_rdata;
					end
				end
				st_rdata: begin
					if (m_rvalid)
						state_q <= st_idle;
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	// Held payload depends on the combiner keeping the request stable
	assert property (@(posedge clk) disable iff (!rst_n)
		m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr));
	assert property (@(posedge clk) disable iff (!rst_n)
		m_wvalid && !m_wready |=> m_wvalid && $stable(m_wdata) && $stable(m_wstrb));
	assert property (@(posedge clk) disable iff (!rst_n)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr));

endmodule

`default_nettype wire

/* verilog/target_if.sv */
`default_nettype none
`timescale 1ns/1ns

// Request from the combiner to one responder
interface target_req_if;
	import pci_bridge_pkg::*;

	addr_t addr;
	data_t wdata;
	be_t   be;
	logic  write;
	logic  req;

	modport master (output addr, wdata, be, write, req);
	modport slave (input addr, wdata, be, write, req);
endinterface

// Completion from a responder back to the combiner
interface target_rsp_if;
	import pci_bridge_pkg::*;

	data_t rdata;
	logic  done;
	logic  err;

	modport master (input rdata, done, err);
	modport slave (output rdata, done, err);
endinterface

`default_nettype wire

/* verilog/pci_bridge_pkg.sv */
`default_nettype none

package pci_bridge_pkg;

	// PCI and AXI address
	typedef logic [31:0] addr_t;

	typedef logic [31:0] data_t;

	// Byte enables, active high
	typedef logic [3:0] be_t;

	// AXI response code
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t AXI_OKAY = 2'b00;

	// Which responder owns the current access
	typedef enum logic [1:0] {
		sel_none,
		sel_window,
		sel_local
	} tgt_sel_t;

endpackage

`default_nettype wire

/* verilog/pci_bridge_macros.svh */
`ifndef PCI_BRIDGE_MACROS_SVH
`define PCI_BRIDGE_MACROS_SVH

// Low PCI address bits passed through to the AXI window
`define PCI_WIN_ADDR_BITS 24

// AXI base of the BAR0 window
`define PCI_WIN_BASE 32'h4000_0000

// Identity word, read back from register 0
`define PCI_REG_ID 32'h5043_4931

`define PCI_REG_WORDS 4

`endif
